// File: verilog/event_pkg.sv
package event_pkg;

    ////////////////////////////////////////////////////////////
    // Table and field sizes
    ////////////////////////////////////////////////////////////
    localparam int OBJ_LIMIT     = 8;
    localparam int SLOT_W        = 3;
    localparam int R_W           = 4;
    localparam int THETA_W       = 9;
    localparam int HP_W          = 2;
    localparam int SCORE_W       = 16;
    localparam int COUNT_W       = 4;
    localparam int FRAME_CTR_W   = 8;

    ////////////////////////////////////////////////////////////
    // Game constants
    ////////////////////////////////////////////////////////////
    localparam int R_LIMIT       = 15;  // Ring of an idle slot.
    localparam int LASER_R_MAX   = 15;
    localparam int THETA_MAX     = 359;
    localparam int LSR_WIDTH     = 10;  // Half cone of the laser in degrees.
    localparam int QUAD_DEG      = 90;
    localparam int LASER_DEG_OFS = 45;  // Laser flies through the quadrant middle.
    localparam int SCORE_HIT     = 10;
    localparam int SCORE_KILL    = 100;

    // Frame counter phases.
    localparam int MOVE_PHASE    = 128; // One ring per counter wrap of 256 frames.
    localparam int BLINK_PHASE   = 16;
    localparam int DEATH_PHASE   = 4;
    localparam int SWAY_BIT      = 6;

    ////////////////////////////////////////////////////////////
    // Frame word layout
    ////////////////////////////////////////////////////////////
    localparam int ENTRY_W       = 11;
    localparam int LASER_FIELD_W = 7;
    localparam int FRAME_DATA_W  = LASER_FIELD_W + OBJ_LIMIT * ENTRY_W;

    typedef enum logic [1:0] {
        INACTIVE = 2'd0,
        ACTIVE   = 2'd1,
        DYING    = 2'd2
    } alien_state_e;

    typedef enum logic [1:0] {
        TYPE0 = 2'd0,  // Sways, clockwise first.
        TYPE1 = 2'd1,  // Sways, counter-clockwise first.
        TYPE2 = 2'd2,  // Fast clockwise.
        TYPE3 = 2'd3   // Fast counter-clockwise.
    } alien_type_e;

    // Player pointing into quadrant 0 to 3.
    typedef enum logic [1:0] {
        DIR0 = 2'd0,
        DIR1 = 2'd1,
        DIR2 = 2'd2,
        DIR3 = 2'd3
    } four_dir_e;

endpackage

// File: verilog/frame_timer.sv
module frame_timer
    import event_pkg::*;
(
    input  logic clk_frame,
    input  logic rst,
    input  logic en,
    output logic move_step,
    output logic blink,
    output logic death_step,
    output logic sway,
    output logic double_step
);

    logic [FRAME_CTR_W-1:0] frame_ctr;

    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst) begin
            frame_ctr <= '0;
        end else if (en) begin
            frame_ctr <= frame_ctr + 1'b1;
        end
    end

    // Each decode matches a single counter value per period.
    assign move_step   = frame_ctr == FRAME_CTR_W'(MOVE_PHASE);
    assign blink       = frame_ctr[4:0] == 5'(BLINK_PHASE);
    assign death_step  = frame_ctr[2:0] == 3'(DEATH_PHASE);

    assign sway        = frame_ctr[SWAY_BIT];  // Direction flips every 64 frames.
    assign double_step = frame_ctr[0];

endmodule

// File: verilog/alien_slot.sv
module alien_slot
    import event_pkg::*;
(
    input  logic               clk_frame,
    input  logic               rst,
    input  logic               en,
    input  logic               load,
    input  logic               hit,
    input  logic               move_step,
    input  logic               blink,
    input  logic               death_step,
    input  logic               sway,
    input  logic               double_step,
    input  alien_type_e        spawn_type,
    input  logic [R_W-1:0]     spawn_r,
    input  logic [THETA_W-1:0] spawn_theta,
    input  logic [HP_W-1:0]    spawn_hp,
    output alien_state_e       state,
    output alien_type_e        kind,
    output logic [1:0]         frame_num,
    output logic [R_W-1:0]     r,
    output logic [THETA_W-1:0] theta,
    output logic               fatal
);

    logic [HP_W-1:0]    hp;
    logic               step_up;
    logic [THETA_W-1:0] step_mag;
    logic [THETA_W-1:0] theta_sum;
    logic [THETA_W-1:0] theta_next;

    assign fatal = hp == HP_W'(1);

    ////////////////////////////////////////////////////////////
    // Angular movement per type
    ////////////////////////////////////////////////////////////
    always_comb begin
        step_up  = 1'b1;
        step_mag = THETA_W'(1);
        case (kind)
            TYPE0: step_up = !sway;
            TYPE1: step_up = sway;
            TYPE2: begin
                step_up  = 1'b1;
                step_mag = double_step ? THETA_W'(2) : THETA_W'(1);
            end
            TYPE3: begin
                step_up  = 1'b0;
                step_mag = double_step ? THETA_W'(2) : THETA_W'(1);
            end
            default: ;
        endcase
    end

    assign theta_sum = theta + step_mag;

    // Wrap within 0..359 in both directions.
    always_comb begin
        if (step_up) begin
            if (theta_sum > THETA_W'(THETA_MAX)) begin
                theta_next = theta_sum - THETA_W'(THETA_MAX + 1);
            end else begin
                theta_next = theta_sum;
            end
        end else if (theta < step_mag) begin
            theta_next = theta + THETA_W'(THETA_MAX + 1) - step_mag;
        end else begin
            theta_next = theta - step_mag;
        end
    end

    ////////////////////////////////////////////////////////////
    // Slot state
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst) begin
            state     <= INACTIVE;
            kind      <= TYPE0;
            frame_num <= 2'd0;
            r         <= R_W'(R_LIMIT);
            theta     <= '0;
            hp        <= '0;
        end else if (en) begin
            if (load) begin
                state     <= ACTIVE;
                kind      <= spawn_type;
                frame_num <= 2'd0;
                r         <= spawn_r;
                theta     <= spawn_theta;
                hp        <= spawn_hp;
            end else begin
                case (state)
                    ACTIVE: begin
                        if (move_step) begin
                            r <= r - 1'b1;
                        end
                        if (blink) begin
                            frame_num[0] <= ~frame_num[0];
                        end
                        theta <= theta_next;
                        if (hit) begin
                            hp <= hp - 1'b1;
                            if (fatal) begin
                                state     <= DYING;
                                frame_num <= 2'd2;  // First death frame.
                            end
                        end
                    end
                    DYING: begin
                        if (death_step) begin
                            if (frame_num == 2'd3) begin
                                state <= INACTIVE;
                            end else begin
                                frame_num <= frame_num + 2'd1;
                            end
                        end
                    end
                    default: ;
                endcase
            end
        end
    end

endmodule

// File: verilog/laser_unit.sv
module laser_unit
    import event_pkg::*;
(
    input  logic                 clk_frame,
    input  logic                 rst,
    input  logic                 en,
    input  logic                 spawn_laser,
    input  four_dir_e            dir,
    input  alien_state_e         slot_state [OBJ_LIMIT],
    input  logic [R_W-1:0]       slot_r     [OBJ_LIMIT],
    input  logic [THETA_W-1:0]   slot_theta [OBJ_LIMIT],
    input  logic                 slot_fatal [OBJ_LIMIT],
    output logic [OBJ_LIMIT-1:0] hit,
    output logic                 kill,
    output logic                 laser_active,
    output logic [R_W-1:0]       laser_r,
    output logic [THETA_W-1:0]   laser_deg,
    output logic [SCORE_W-1:0]   score
);

    logic               searching;
    logic               found;
    logic               found_fatal;
    logic [THETA_W-1:0] cone_lo;
    logic [THETA_W-1:0] cone_hi;

    // Laser angles sit at 45 + 90k, so the cone never wraps.
    assign cone_lo   = laser_deg - THETA_W'(LSR_WIDTH);
    assign cone_hi   = laser_deg + THETA_W'(LSR_WIDTH);
    assign searching = laser_active && (laser_r != R_W'(LASER_R_MAX));

    ////////////////////////////////////////////////////////////
    // Collision search, lowest slot wins
    ////////////////////////////////////////////////////////////
    always_comb begin
        hit         = '0;
        found       = 1'b0;
        found_fatal = 1'b0;
        for (int i = 0; i < OBJ_LIMIT; i++) begin
            if (searching && !found && slot_state[i] == ACTIVE
                    && slot_r[i] == laser_r
                    && slot_theta[i] >= cone_lo
                    && slot_theta[i] <= cone_hi) begin
                hit[i]      = 1'b1;
                found       = 1'b1;
                found_fatal = slot_fatal[i];
            end
        end
    end

    assign kill = found && found_fatal;

    ////////////////////////////////////////////////////////////
    // Flight and score
    ////////////////////////////////////////////////////////////
    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst) begin
            laser_active <= 1'b0;
            laser_r      <= '0;
            laser_deg    <= '0;
            score        <= '0;
        end else if (en) begin
            if (!laser_active) begin
                // Idle laser tracks the player until fired.
                laser_r      <= '0;
                laser_deg    <= THETA_W'(dir) * THETA_W'(QUAD_DEG) + THETA_W'(LASER_DEG_OFS);
                laser_active <= spawn_laser;
            end else if (!searching) begin
                laser_active <= 1'b0;  // Left the play field.
            end else if (found) begin
                laser_active <= 1'b0;
                if (found_fatal) begin
                    score <= score + SCORE_W'(SCORE_KILL);
                end else begin
                    score <= score + SCORE_W'(SCORE_HIT);
                end
            end else begin
                laser_r <= laser_r + 1'b1;
            end
        end
    end

endmodule

// File: verilog/distance_sorter.sv
module distance_sorter
    import event_pkg::*;
(
    input  logic              clk_frame,
    input  logic              rst,
    input  logic              en,
    input  logic [R_W-1:0]    keys  [OBJ_LIMIT],
    output logic [SLOT_W-1:0] order [OBJ_LIMIT]
);

    // Index permutation after each stage; stage 0 is identity.
    logic [SLOT_W-1:0] net [OBJ_LIMIT+1][OBJ_LIMIT];

    ////////////////////////////////////////////////////////////
    // Odd-even transposition network
    ////////////////////////////////////////////////////////////
    always_comb begin
        for (int i = 0; i < OBJ_LIMIT; i++) begin
            net[0][i] = SLOT_W'(i);
        end
        for (int s = 0; s < OBJ_LIMIT; s++) begin
            for (int i = 0; i < OBJ_LIMIT; i++) begin
                net[s+1][i] = net[s][i];
            end
            // Even stages pair (0,1),(2,3); odd stages pair (1,2),(3,4).
            for (int j = s % 2; j < OBJ_LIMIT - 1; j += 2) begin
                if (keys[net[s][j+1]] < keys[net[s][j]]) begin  // Strict, keeps ties.
                    net[s+1][j]   = net[s][j+1];
                    net[s+1][j+1] = net[s][j];
                end
            end
        end
    end

    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < OBJ_LIMIT; i++) begin
                order[i] <= SLOT_W'(i);
            end
        end else if (en) begin
            order <= net[OBJ_LIMIT];
        end
    end

endmodule

// File: verilog/event_core.sv
module event_core
    import event_pkg::*;
(
    input  logic                    clk_frame,
    input  logic                    rst,
    input  logic                    en,
    input  logic                    spawn_laser,
    input  logic                    spawn_object,
    input  four_dir_e               dir,
    input  alien_type_e             spawn_type,
    input  logic [R_W-1:0]          spawn_r,
    input  logic [THETA_W-1:0]      spawn_theta,
    input  logic [HP_W-1:0]         spawn_hp,
    output logic [SCORE_W-1:0]      score,
    output logic                    all_clear,
    output logic                    game_over,
    output logic [COUNT_W-1:0]      object_count,
    output logic [FRAME_DATA_W-1:0] frame_data
);

    logic move_step, blink, death_step, sway, double_step;
    logic spawn_q, spawn_rise, spawn_accept, free_found;
    logic kill, laser_active;
    logic [R_W-1:0]       laser_r;
    logic [THETA_W-1:0]   laser_deg;
    logic [OBJ_LIMIT-1:0] free_sel;
    logic [OBJ_LIMIT-1:0] load;
    logic [OBJ_LIMIT-1:0] slot_hit;

    alien_state_e       slot_state [OBJ_LIMIT];
    alien_type_e        slot_kind  [OBJ_LIMIT];
    logic [1:0]         slot_frame [OBJ_LIMIT];
    logic [R_W-1:0]     slot_r     [OBJ_LIMIT];
    logic [THETA_W-1:0] slot_theta [OBJ_LIMIT];
    logic               slot_fatal [OBJ_LIMIT];
    logic [SLOT_W-1:0]  order      [OBJ_LIMIT];

    // Slot table as it stood one frame back, aligned with order.
    alien_state_e       snap_state [OBJ_LIMIT];
    alien_type_e        snap_kind  [OBJ_LIMIT];
    logic [1:0]         snap_frame [OBJ_LIMIT];
    logic [R_W-1:0]     snap_r     [OBJ_LIMIT];
    logic [THETA_W-1:0] snap_theta [OBJ_LIMIT];

    frame_timer timer_i (.*);

    for (genvar g = 0; g < OBJ_LIMIT; g++) begin : g_slot
        alien_slot slot_i (
            .clk_frame, .rst, .en, .load(load[g]), .hit(slot_hit[g]),
            .move_step, .blink, .death_step, .sway, .double_step,
            .spawn_type, .spawn_r, .spawn_theta, .spawn_hp,
            .state(slot_state[g]), .kind(slot_kind[g]), .frame_num(slot_frame[g]),
            .r(slot_r[g]), .theta(slot_theta[g]), .fatal(slot_fatal[g])
        );
    end

    laser_unit laser_i (
        .clk_frame, .rst, .en, .spawn_laser, .dir,
        .slot_state, .slot_r, .slot_theta, .slot_fatal,
        .hit(slot_hit), .kill, .laser_active, .laser_r, .laser_deg, .score
    );

    distance_sorter sorter_i (.clk_frame, .rst, .en, .keys(slot_r), .order);

    ////////////////////////////////////////////////////////////
    // Spawn, live count and flags
    ////////////////////////////////////////////////////////////
    assign spawn_rise = spawn_object && !spawn_q;

    always_comb begin
        free_sel   = '0;
        free_found = 1'b0;
        all_clear  = 1'b1;
        game_over  = 1'b0;
        for (int i = 0; i < OBJ_LIMIT; i++) begin
            if (!free_found && slot_state[i] == INACTIVE) begin
                free_sel[i] = 1'b1;  // Lowest free slot.
                free_found  = 1'b1;
            end
            if (slot_state[i] != INACTIVE) all_clear = 1'b0;
            if (slot_state[i] == ACTIVE && slot_r[i] == '0) game_over = 1'b1;
        end
    end

    assign spawn_accept = spawn_rise && free_found;  // Full table drops it.
    assign load         = spawn_accept ? free_sel : '0;

    always_ff @(posedge clk_frame or posedge rst) begin
        if (rst) begin
            spawn_q      <= 1'b0;
            object_count <= '0;
            for (int i = 0; i < OBJ_LIMIT; i++) begin
                snap_state[i] <= INACTIVE;
                snap_kind[i]  <= TYPE0;
                snap_frame[i] <= 2'd0;
                snap_r[i]     <= R_W'(R_LIMIT);
                snap_theta[i] <= '0;
            end
        end else if (en) begin
            spawn_q      <= spawn_object;
            object_count <= object_count + COUNT_W'(spawn_accept) - COUNT_W'(kill);
            snap_state   <= slot_state;
            snap_kind    <= slot_kind;
            snap_frame   <= slot_frame;
            snap_r       <= slot_r;
            snap_theta   <= slot_theta;
        end
    end

    ////////////////////////////////////////////////////////////
    // Frame word
    ////////////////////////////////////////////////////////////
    assign frame_data[0]   = laser_active;
    assign frame_data[4:1] = laser_r;
    assign frame_data[6:5] = 2'(laser_deg / QUAD_DEG);

    for (genvar k = 0; k < OBJ_LIMIT; k++) begin : g_entry
        localparam int BASE = LASER_FIELD_W + k * ENTRY_W;
        assign frame_data[BASE]            = snap_state[order[k]] != INACTIVE;
        assign frame_data[BASE+2:BASE+1]   = snap_kind[order[k]];
        assign frame_data[BASE+4:BASE+3]   = snap_frame[order[k]];
        assign frame_data[BASE+8:BASE+5]   = snap_r[order[k]];
        assign frame_data[BASE+10:BASE+9]  = 2'(snap_theta[order[k]] / QUAD_DEG);
    end

endmodule

// File: sim/event_core_tb.sv
module event_core_tb
    import event_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int RESET_CYCLES = 16;
    localparam int TEST_CYCLES  = 4000;
    localparam int CYCLE_LIMIT  = 4200;  // Reset and test length plus margin.

    logic clk_frame = 1'b0;
    logic rst, en, spawn_laser, spawn_object;
    four_dir_e               dir;
    alien_type_e             spawn_type;
    logic [R_W-1:0]          spawn_r;
    logic [THETA_W-1:0]      spawn_theta;
    logic [HP_W-1:0]         spawn_hp;
    logic [SCORE_W-1:0]      score;
    logic                    all_clear, game_over;
    logic [COUNT_W-1:0]      object_count;
    logic [FRAME_DATA_W-1:0] frame_data;

    integer seed;
    int     errors = 0;
    int     cycle_count = 0;

    ////////////////////////////////////////////////////////////
    // Reference model state
    ////////////////////////////////////////////////////////////
    logic [FRAME_CTR_W-1:0] m_ctr;
    alien_state_e m_state [OBJ_LIMIT];
    alien_type_e  m_kind  [OBJ_LIMIT];
    int           m_frame [OBJ_LIMIT];
    int           m_r     [OBJ_LIMIT];
    int           m_theta [OBJ_LIMIT];
    int           m_hp    [OBJ_LIMIT];
    alien_state_e p_state [OBJ_LIMIT];  // Table one frame back.
    alien_type_e  p_kind  [OBJ_LIMIT];
    int           p_frame [OBJ_LIMIT];
    int           p_r     [OBJ_LIMIT];
    int           p_theta [OBJ_LIMIT];
    int           m_order [OBJ_LIMIT];
    bit           m_lsr_on, m_spawn_q;
    int           m_lsr_r, m_lsr_deg, m_score, m_count;

    event_core dut_i (
        .clk_frame(clk_frame), .rst(rst), .en(en), .spawn_laser(spawn_laser),
        .spawn_object(spawn_object), .dir(dir), .spawn_type(spawn_type),
        .spawn_r(spawn_r), .spawn_theta(spawn_theta), .spawn_hp(spawn_hp),
        .score(score), .all_clear(all_clear), .game_over(game_over),
        .object_count(object_count), .frame_data(frame_data)
    );

    always #10 clk_frame = ~clk_frame;

    always @(posedge clk_frame) begin
        cycle_count++;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("sim failed");
            $finish;
        end
    end

    function automatic int rand_below(input int n);
        return int'({$random(seed)} % n);
    endfunction

    task automatic check_field(input string field, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("ERR %0t: %s got %0d expected %0d", $time, field, got, exp);
        end
    endtask

    task automatic reset_model();
        m_ctr = '0;
        for (int i = 0; i < OBJ_LIMIT; i++) begin
            m_state[i] = INACTIVE;
            m_kind[i]  = TYPE0;
            m_frame[i] = 0;
            m_r[i]     = R_LIMIT;
            m_theta[i] = 0;
            m_hp[i]    = 0;
            m_order[i] = i;
        end
        p_state = m_state;
        p_kind  = m_kind;
        p_frame = m_frame;
        p_r     = m_r;
        p_theta = m_theta;
        m_lsr_on  = 1'b0;
        m_spawn_q = 1'b0;
        m_lsr_r   = 0;
        m_lsr_deg = 0;
        m_score   = 0;
        m_count   = 0;
    endtask

    ////////////////////////////////////////////////////////////
    // One enabled frame of the game rules
    ////////////////////////////////////////////////////////////
    task automatic step_model();
        bit move, blink, death, sway, dbl, rise, kill;
        int hit_slot;
        int free_slot;
        int step;
        int n;
        move  = m_ctr == 8'd128;
        blink = m_ctr[4:0] == 5'd16;
        death = m_ctr[2:0] == 3'd4;
        sway  = m_ctr[6];
        dbl   = m_ctr[0];
        p_state = m_state;
        p_kind  = m_kind;
        p_frame = m_frame;
        p_r     = m_r;
        p_theta = m_theta;
        n = 0;
        for (int ring = 0; ring <= R_LIMIT; ring++) begin
            for (int i = 0; i < OBJ_LIMIT; i++) begin
                if (m_r[i] == ring) begin
                    m_order[n] = i;  // Stable by slot index.
                    n++;
                end
            end
        end
        hit_slot  = -1;
        free_slot = -1;
        for (int i = OBJ_LIMIT - 1; i >= 0; i--) begin
            if (m_state[i] == INACTIVE) free_slot = i;
            if (m_lsr_on && m_lsr_r != LASER_R_MAX && m_state[i] == ACTIVE
                    && m_r[i] == m_lsr_r && m_theta[i] >= m_lsr_deg - LSR_WIDTH
                    && m_theta[i] <= m_lsr_deg + LSR_WIDTH) hit_slot = i;
        end
        kill = hit_slot >= 0 && m_hp[hit_slot] == 1;
        rise = spawn_object && !m_spawn_q;
        if (!m_lsr_on) begin
            m_lsr_r   = 0;
            m_lsr_deg = int'(dir) * 90 + 45;
            m_lsr_on  = spawn_laser;
        end else if (m_lsr_r == LASER_R_MAX || hit_slot >= 0) begin
            m_lsr_on = 1'b0;
            if (hit_slot >= 0) m_score = (m_score + (kill ? SCORE_KILL : SCORE_HIT)) % 65536;
        end else begin
            m_lsr_r++;
        end
        for (int i = 0; i < OBJ_LIMIT; i++) begin
            if (rise && i == free_slot) begin
                m_state[i] = ACTIVE;
                m_kind[i]  = spawn_type;
                m_frame[i] = 0;
                m_r[i]     = spawn_r;
                m_theta[i] = spawn_theta;
                m_hp[i]    = spawn_hp;
            end else if (m_state[i] == ACTIVE) begin
                if (move) m_r[i] = (m_r[i] + 15) % 16;
                if (blink) m_frame[i] = m_frame[i] ^ 1;
                case (m_kind[i])
                    TYPE0:   step = sway ? -1 : 1;
                    TYPE1:   step = sway ? 1 : -1;
                    TYPE2:   step = dbl ? 2 : 1;
                    default: step = dbl ? -2 : -1;
                endcase
                m_theta[i] = (m_theta[i] + step + 360) % 360;
                if (i == hit_slot) begin
                    if (m_hp[i] == 1) begin
                        m_state[i] = DYING;
                        m_frame[i] = 2;
                    end
                    m_hp[i]--;
                end
            end else if (m_state[i] == DYING && death) begin
                if (m_frame[i] == 3) m_state[i] = INACTIVE;
                else m_frame[i]++;
            end
        end
        m_count   = m_count + int'(rise && free_slot >= 0) - int'(kill);
        m_spawn_q = spawn_object;
        m_ctr     = m_ctr + 1'b1;
    endtask

    task automatic compare_outputs();
        int clear_exp;
        int over_exp;
        int s;
        int entry_exp;
        clear_exp = 1;
        over_exp  = 0;
        for (int i = 0; i < OBJ_LIMIT; i++) begin
            if (m_state[i] != INACTIVE) clear_exp = 0;
            if (m_state[i] == ACTIVE && m_r[i] == 0) over_exp = 1;
        end
        check_field("score", score, m_score);
        check_field("object_count", object_count, m_count);
        check_field("all_clear", all_clear, clear_exp);
        check_field("game_over", game_over, over_exp);
        check_field("laser active", frame_data[0], m_lsr_on);
        check_field("laser ring", frame_data[4:1], m_lsr_r);
        check_field("laser quadrant", frame_data[6:5], m_lsr_deg / 90);
        for (int k = 0; k < OBJ_LIMIT; k++) begin
            s = m_order[k];
            entry_exp = int'(p_state[s] != INACTIVE) | (int'(p_kind[s]) << 1)
                      | (p_frame[s] << 3) | (p_r[s] << 5) | ((p_theta[s] / 90) << 9);
            check_field($sformatf("entry %0d", k),
                        frame_data[LASER_FIELD_W + k * ENTRY_W +: ENTRY_W], entry_exp);
        end
    endtask

    task automatic drive_inputs();
        en = rand_below(100) >= 5;
        if (rand_below(16) == 0) spawn_object = !spawn_object;
        spawn_laser = rand_below(4) == 0;
        dir         = four_dir_e'(rand_below(4));
        spawn_type  = alien_type_e'(rand_below(4));
        spawn_r     = R_W'(4 + rand_below(12));
        // Half the spawns start inside a laser cone.
        if (rand_below(2) == 0) spawn_theta = THETA_W'(35 + 90 * rand_below(4) + rand_below(21));
        else spawn_theta = THETA_W'(rand_below(360));
        spawn_hp = HP_W'(1 + rand_below(3));
    endtask

    initial begin
        seed         = 12602;
        rst          = 1'b1;
        en           = 1'b0;
        spawn_laser  = 1'b0;
        spawn_object = 1'b0;
        dir          = DIR0;
        spawn_type   = TYPE0;
        spawn_r      = '0;
        spawn_theta  = '0;
        spawn_hp     = '0;
        reset_model();
        repeat (RESET_CYCLES) begin
            @(negedge clk_frame);
            compare_outputs();
        end
        rst = 1'b0;
        for (int c = 0; c < TEST_CYCLES; c++) begin
            drive_inputs();
            if (en) step_model();
            @(negedge clk_frame);
            compare_outputs();
        end
        $display("Checked %0d cycles, %0d errors", TEST_CYCLES, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

// File: compile.f
verilog/event_pkg.sv
verilog/frame_timer.sv
verilog/alien_slot.sv
verilog/laser_unit.sv
verilog/distance_sorter.sv
verilog/event_core.sv
sim/event_core_tb.sv
